// File: logic/lsu_types_pkg.sv
package lsu_types_pkg;

    // register value as seen on the broadcast buses
    typedef logic [31:0] data_t;

    // byte address, the memory only decodes the low bits
    typedef logic [31:0] addr_t;

    // already sign-extended by the decoder upstream
    typedef logic [31:0] imm_t;

    // access size in bytes, 1, 2 or 4
    typedef logic [2:0] len_t;

    // nick 0 is reserved for "value present"
    localparam int NICK_W_DEF = 4;

    // 1 KiB of data memory by default
    localparam int MEM_AW_DEF = 10;

endpackage

// File: logic/lsu_op_pkg.sv
package lsu_op_pkg;

    // internal opcode as handed over by dispatch
    typedef logic [5:0] op_t;

    // loads
    localparam op_t OP_LB  = 6'h0b;
    localparam op_t OP_LH  = 6'h0c;
    localparam op_t OP_LW  = 6'h0d;
    localparam op_t OP_LBU = 6'h0e;
    localparam op_t OP_LHU = 6'h0f;

    // stores
    localparam op_t OP_SB  = 6'h10;
    localparam op_t OP_SH  = 6'h11;
    localparam op_t OP_SW  = 6'h12;

    // access kind as kept per buffer entry
    localparam logic LS_LOAD  = 1'b0;
    localparam logic LS_STORE = 1'b1;

    // access sizes
    localparam lsu_types_pkg::len_t LEN_ONE  = 3'd1;
    localparam lsu_types_pkg::len_t LEN_TWO  = 3'd2;
    localparam lsu_types_pkg::len_t LEN_FOUR = 3'd4;

endpackage

// File: logic/mem_op_decode.sv
`timescale 1ns/100ps

module mem_op_decode (
    input  lsu_op_pkg::op_t     op,
    output logic                is_mem,
    output logic                is_store,
    output lsu_types_pkg::len_t len,
    output logic                is_unsigned
);
    import lsu_op_pkg::*;

    always_comb begin
        is_mem      = 1'b1;
        is_store    = LS_LOAD;
        len         = LEN_FOUR;
        is_unsigned = 1'b0;
        case (op)
            OP_LB:  len = LEN_ONE;
            OP_LH:  len = LEN_TWO;
            OP_LW:  len = LEN_FOUR;
            OP_LBU: begin
                len         = LEN_ONE;
                is_unsigned = 1'b1;
            end
            OP_LHU: begin
                len         = LEN_TWO;
                is_unsigned = 1'b1;
            end
            OP_SB: begin
                is_store = LS_STORE;
                len      = LEN_ONE;
            end
            OP_SH: begin
                is_store = LS_STORE;
                len      = LEN_TWO;
            end
            OP_SW: is_store = LS_STORE;
            // anything else belongs to another unit
            default: is_mem = 1'b0;
        endcase
    end

endmodule

// File: logic/slb.sv
`timescale 1ns/100ps

module slb #(
    parameter int NICK_W = lsu_types_pkg::NICK_W_DEF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rdy,
    input  logic                 clr,
    input  logic                 dp_en,
    input  logic                 dp_is_mem,
    input  logic                 dp_is_store,
    input  lsu_types_pkg::len_t  dp_len,
    input  logic                 dp_unsigned,
    input  lsu_types_pkg::imm_t  dp_imm,
    input  logic [NICK_W-1:0]    dp_rd_nick,
    input  logic [NICK_W-1:0]    dp_rs1_nick,
    input  lsu_types_pkg::data_t dp_rs1_data,
    input  logic [NICK_W-1:0]    dp_rs2_nick,
    input  lsu_types_pkg::data_t dp_rs2_data,
    input  logic                 ex_en,
    input  logic [NICK_W-1:0]    ex_nick,
    input  lsu_types_pkg::data_t ex_data,
    input  logic                 res_en,
    input  logic [NICK_W-1:0]    res_nick,
    input  lsu_types_pkg::data_t res_data,
    input  logic                 store_en,
    input  logic [NICK_W-1:0]    store_nick,
    input  logic                 mem_ready,
    output logic                 mem_req,
    output logic                 mem_we,
    output logic [NICK_W-1:0]    mem_nick,
    output lsu_types_pkg::len_t  mem_len,
    output logic                 mem_unsigned,
    output lsu_types_pkg::addr_t mem_addr,
    output lsu_types_pkg::data_t mem_wdata,
    output logic                 store_done,
    output logic                 full
);
    import lsu_types_pkg::*;

    localparam int N = 1 << NICK_W;

    logic [N-1:0]      occupied;
    logic [N-1:0]      issued;
    logic [N-1:0]      is_st;
    logic [N-1:0]      is_uns;
    len_t              len_q    [N];
    imm_t              imm_q    [N];
    // slot 0 is the base register, slot 1 the store data
    logic [NICK_W-1:0] op_nick  [2][N];
    data_t             op_data  [2][N];
    logic              op_valid [2][N];

    logic [NICK_W-1:0] dp_nick [2];
    data_t             dp_data [2];
    logic              issue_ok;
    logic              store_go;
    logic              load_go;
    logic [NICK_W-1:0] load_idx;

    assign dp_nick[0] = dp_rs1_nick;
    assign dp_nick[1] = dp_rs2_nick;
    assign dp_data[0] = dp_rs1_data;
    assign dp_data[1] = dp_rs2_data;

    // entry 0 is never handed out
    assign full = rdy & (&occupied[N-1:1]);

    // a request still on the wire keeps the memory from seeing a second one
    assign issue_ok = mem_ready & ~mem_req;

    assign store_go = store_en & occupied[store_nick] & is_st[store_nick]
                    & op_valid[0][store_nick] & op_valid[1][store_nick];

    // lowest index wins
    always_comb begin
        load_go  = 1'b0;
        load_idx = '0;
        for (int i = N - 1; i > 0; i--) begin
            if (occupied[i] && !is_st[i] && !issued[i] && op_valid[0][i]) begin
                load_go  = 1'b1;
                load_idx = NICK_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied   <= '0;
            issued     <= '0;
            mem_req    <= 1'b0;
            store_done <= 1'b0;
        end else if (!rdy) begin
            mem_req    <= 1'b0;
            store_done <= 1'b0;
        end else if (clr) begin
            occupied   <= '0;
            issued     <= '0;
            mem_req    <= 1'b0;
            store_done <= 1'b0;
        end else begin
            mem_req    <= issue_ok & (store_go | load_go);
            store_done <= issue_ok & store_go;
            // results of flushed loads are not ours any more
            if (res_en && issued[res_nick]) begin
                occupied[res_nick] <= 1'b0;
                issued[res_nick]   <= 1'b0;
            end
            if (issue_ok && store_go) begin
                occupied[store_nick] <= 1'b0;
            end else if (issue_ok && load_go) begin
                issued[load_idx] <= 1'b1;
            end
            if (dp_en && dp_is_mem) begin
                occupied[dp_rd_nick] <= 1'b1;
                issued[dp_rd_nick]   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            // wakeup from both broadcast buses
            for (int k = 0; k < 2; k++) begin
                for (int i = 0; i < N; i++) begin
                    if (!op_valid[k][i] && ex_en && op_nick[k][i] == ex_nick) begin
                        op_valid[k][i] <= 1'b1;
                        op_data[k][i]  <= ex_data;
                    end
                    if (!op_valid[k][i] && res_en && op_nick[k][i] == res_nick) begin
                        op_valid[k][i] <= 1'b1;
                        op_data[k][i]  <= res_data;
                    end
                end
            end

            if (issue_ok && store_go) begin
                mem_we       <= 1'b1;
                mem_nick     <= store_nick;
                mem_len      <= len_q[store_nick];
                mem_unsigned <= is_uns[store_nick];
                mem_addr     <= op_data[0][store_nick] + imm_q[store_nick];
                mem_wdata    <= op_data[1][store_nick];
            end else if (issue_ok && load_go) begin
                mem_we       <= 1'b0;
                mem_nick     <= load_idx;
                mem_len      <= len_q[load_idx];
                mem_unsigned <= is_uns[load_idx];
                mem_addr     <= op_data[0][load_idx] + imm_q[load_idx];
                mem_wdata    <= '0;
            end

            if (dp_en && dp_is_mem) begin
                is_st[dp_rd_nick]  <= dp_is_store;
                is_uns[dp_rd_nick] <= dp_unsigned;
                len_q[dp_rd_nick]  <= dp_len;
                imm_q[dp_rd_nick]  <= dp_imm;
                for (int k = 0; k < 2; k++) begin
                    op_nick[k][dp_rd_nick] <= dp_nick[k];
                    // catch a broadcast landing in the dispatch cycle
                    if (dp_nick[k] == '0) begin
                        op_valid[k][dp_rd_nick] <= 1'b1;
                        op_data[k][dp_rd_nick]  <= dp_data[k];
                    end else if (ex_en && ex_nick == dp_nick[k]) begin
                        op_valid[k][dp_rd_nick] <= 1'b1;
                        op_data[k][dp_rd_nick]  <= ex_data;
                    end else if (res_en && res_nick == dp_nick[k]) begin
                        op_valid[k][dp_rd_nick] <= 1'b1;
                        op_data[k][dp_rd_nick]  <= res_data;
                    end else begin
                        op_valid[k][dp_rd_nick] <= 1'b0;
                        op_data[k][dp_rd_nick]  <= dp_data[k];
                    end
                end
            end
        end
    end

endmodule

// File: logic/data_mem.sv
`timescale 1ns/100ps

module data_mem #(
    parameter int MEM_AW = lsu_types_pkg::MEM_AW_DEF
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req,
    input  logic                                  we,
    input  logic [lsu_types_pkg::NICK_W_DEF-1:0]  nick,
    input  lsu_types_pkg::len_t                   len,
    input  logic                                  is_unsigned,
    input  lsu_types_pkg::addr_t                  addr,
    input  lsu_types_pkg::data_t                  wdata,
    output logic                                  ready,
    output logic                                  done,
    output logic [lsu_types_pkg::NICK_W_DEF-1:0]  done_nick,
    output lsu_types_pkg::len_t                   done_len,
    output logic                                  done_unsigned,
    output lsu_types_pkg::data_t                  rdata
);
    import lsu_types_pkg::*;

    localparam int DEPTH = 1 << MEM_AW;
    localparam int LAT   = 2;

    logic [7:0]        mem [DEPTH] = '{default: 8'h00};
    logic [1:0]        busy;
    logic              we_q;
    logic [MEM_AW-1:0] addr_q;
    data_t             rd_word;

    assign ready = (busy == 2'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 2'd0;
            done <= 1'b0;
        end else begin
            // loads report back on the last busy cycle
            done <= (busy == 2'd1) && !we_q;
            if (req && ready) begin
                busy <= 2'(LAT - 1);
            end else if (busy != 2'd0) begin
                busy <= busy - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && ready) begin
            we_q          <= we;
            addr_q        <= addr[MEM_AW-1:0];
            done_nick     <= nick;
            done_len      <= len;
            done_unsigned <= is_unsigned;
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (3'(b) < len) begin
                        mem[addr[MEM_AW-1:0] + MEM_AW'(b)] <= wdata[8*b +: 8];
                    end
                end
            end
        end
        if (busy == 2'd1) begin
            rdata <= rd_word;
        end
    end

    // little-endian gather, zero above len
    always_comb begin
        rd_word = '0;
        for (int b = 0; b < 4; b++) begin
            if (3'(b) < done_len) begin
                rd_word[8*b +: 8] = mem[addr_q + MEM_AW'(b)];
            end
        end
    end

endmodule

// File: logic/load_result.sv
`timescale 1ns/100ps

module load_result #(
    parameter int NICK_W = lsu_types_pkg::NICK_W_DEF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rdy,
    input  logic                 clr,
    input  logic                 done,
    input  logic [NICK_W-1:0]    done_nick,
    input  lsu_types_pkg::len_t  done_len,
    input  logic                 done_unsigned,
    input  lsu_types_pkg::data_t rdata,
    output logic                 res_en,
    output logic [NICK_W-1:0]    res_nick,
    output lsu_types_pkg::data_t res_data
);
    import lsu_types_pkg::*;
    import lsu_op_pkg::*;

    data_t             ext;
    logic              hold_v;
    logic [NICK_W-1:0] hold_nick;
    data_t             hold_data;
    logic              take_hold;

    always_comb begin
        case (done_len)
            LEN_ONE: ext = done_unsigned ? {24'h0, rdata[7:0]} : {{24{rdata[7]}}, rdata[7:0]};
            LEN_TWO: ext = done_unsigned ? {16'h0, rdata[15:0]} : {{16{rdata[15]}}, rdata[15:0]};
            default: ext = rdata;
        endcase
    end

    // park a result that lands during a stall or behind a parked one
    assign take_hold = done & (~rdy | hold_v);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_en <= 1'b0;
            hold_v <= 1'b0;
        end else if (!rdy) begin
            res_en <= 1'b0;
            if (done) begin
                hold_v <= 1'b1;
            end
        end else if (clr) begin
            res_en <= 1'b0;
            hold_v <= 1'b0;
        end else begin
            res_en <= hold_v | done;
            hold_v <= hold_v & done;
        end
    end

    always_ff @(posedge clk) begin
        if (take_hold) begin
            hold_nick <= done_nick;
            hold_data <= ext;
        end
        if (rdy) begin
            if (hold_v) begin
                res_nick <= hold_nick;
                res_data <= hold_data;
            end else if (done) begin
                res_nick <= done_nick;
                res_data <= ext;
            end
        end
    end

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/100ps

module lsu_top #(
    parameter int NICK_W = lsu_types_pkg::NICK_W_DEF,
    parameter int MEM_AW = lsu_types_pkg::MEM_AW_DEF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rdy,
    input  logic                 clr,
    input  logic                 dp_en,
    input  lsu_op_pkg::op_t      dp_op,
    input  lsu_types_pkg::imm_t  dp_imm,
    input  logic [NICK_W-1:0]    dp_rd_nick,
    input  logic [NICK_W-1:0]    dp_rs1_nick,
    input  lsu_types_pkg::data_t dp_rs1_data,
    input  logic [NICK_W-1:0]    dp_rs2_nick,
    input  lsu_types_pkg::data_t dp_rs2_data,
    input  logic                 ex_en,
    input  logic [NICK_W-1:0]    ex_nick,
    input  lsu_types_pkg::data_t ex_data,
    input  logic                 store_en,
    input  logic [NICK_W-1:0]    store_nick,
    output logic                 res_en,
    output logic [NICK_W-1:0]    res_nick,
    output lsu_types_pkg::data_t res_data,
    output logic                 store_done,
    output logic                 full
);
    import lsu_types_pkg::*;

    logic              dec_is_mem;
    logic              dec_is_store;
    len_t              dec_len;
    logic              dec_unsigned;
    logic              mem_req;
    logic              mem_we;
    logic [NICK_W-1:0] mem_nick;
    len_t              mem_len;
    logic              mem_unsigned;
    addr_t             mem_addr;
    data_t             mem_wdata;
    logic              mem_ready;
    logic              mem_done;
    logic [NICK_W-1:0] mem_done_nick;
    len_t              mem_done_len;
    logic              mem_done_unsigned;
    data_t             mem_rdata;

    mem_op_decode dec_i (
        .op(dp_op), .is_mem(dec_is_mem), .is_store(dec_is_store),
        .len(dec_len), .is_unsigned(dec_unsigned)
    );

    slb #(.NICK_W(NICK_W)) slb_i (
        .clk(clk), .rst_n(rst_n), .rdy(rdy), .clr(clr),
        .dp_en(dp_en), .dp_is_mem(dec_is_mem), .dp_is_store(dec_is_store),
        .dp_len(dec_len), .dp_unsigned(dec_unsigned), .dp_imm(dp_imm),
        .dp_rd_nick(dp_rd_nick), .dp_rs1_nick(dp_rs1_nick), .dp_rs1_data(dp_rs1_data),
        .dp_rs2_nick(dp_rs2_nick), .dp_rs2_data(dp_rs2_data),
        .ex_en(ex_en), .ex_nick(ex_nick), .ex_data(ex_data),
        .res_en(res_en), .res_nick(res_nick), .res_data(res_data),
        .store_en(store_en), .store_nick(store_nick), .mem_ready(mem_ready),
        .mem_req(mem_req), .mem_we(mem_we), .mem_nick(mem_nick), .mem_len(mem_len),
        .mem_unsigned(mem_unsigned), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .store_done(store_done), .full(full)
    );

    data_mem #(.MEM_AW(MEM_AW)) mem_i (
        .clk(clk), .rst_n(rst_n), .req(mem_req), .we(mem_we), .nick(mem_nick),
        .len(mem_len), .is_unsigned(mem_unsigned), .addr(mem_addr), .wdata(mem_wdata),
        .ready(mem_ready), .done(mem_done), .done_nick(mem_done_nick),
        .done_len(mem_done_len), .done_unsigned(mem_done_unsigned), .rdata(mem_rdata)
    );

    load_result #(.NICK_W(NICK_W)) res_i (
        .clk(clk), .rst_n(rst_n), .rdy(rdy), .clr(clr), .done(mem_done),
        .done_nick(mem_done_nick), .done_len(mem_done_len),
        .done_unsigned(mem_done_unsigned), .rdata(mem_rdata),
        .res_en(res_en), .res_nick(res_nick), .res_data(res_data)
    );

endmodule

// File: test/lsu_checker.sv
`timescale 1ns/100ps

module lsu_checker #(
    parameter int NICK_W = 4
) (
    input logic              clk,
    input logic              rst_n,
    input logic              rdy,
    input logic              clr,
    input logic              dp_en,
    input logic              dp_is_mem,
    input logic [NICK_W-1:0] dp_rd_nick,
    input logic              mem_req,
    input logic              mem_ready,
    input logic              mem_we,
    input logic              store_done,
    input logic              res_en,
    input logic [NICK_W-1:0] res_nick,
    input logic              full
);
    // nicks that may still produce one load result
    logic [(1<<NICK_W)-1:0] live;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            live <= '0;
        end else begin
            if (res_en) begin
                live[res_nick] <= 1'b0;
            end
            if (rdy && clr) begin
                live <= '0;
            end else if (rdy && dp_en && dp_is_mem) begin
                live[dp_rd_nick] <= 1'b1;
            end
        end
    end

    a_req_ready: assert property (@(posedge clk) disable iff (!rst_n) mem_req |-> mem_ready)
        else $error("memory request while the memory is busy");

    a_store_we: assert property (@(posedge clk) disable iff (!rst_n) store_done |-> mem_we)
        else $error("store_done without a write request");

    a_res_once: assert property (@(posedge clk) disable iff (!rst_n) res_en |-> live[res_nick])
        else $error("load result repeated without a new dispatch");

    a_full_reset: assert property (@(posedge clk) !rst_n |-> !full)
        else $error("full high during reset");

endmodule

bind lsu_top lsu_checker #(.NICK_W(NICK_W)) chk_i (
    .clk(clk), .rst_n(rst_n), .rdy(rdy), .clr(clr), .dp_en(dp_en),
    .dp_is_mem(dec_is_mem), .dp_rd_nick(dp_rd_nick), .mem_req(mem_req),
    .mem_ready(mem_ready), .mem_we(mem_we), .store_done(store_done),
    .res_en(res_en), .res_nick(res_nick), .full(full)
);

// File: test/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb;
    import lsu_types_pkg::*;
    import lsu_op_pkg::*;

    localparam int NW  = 4;
    localparam int TMO = 300;
    localparam op_t LD_OPS [5] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    localparam op_t ST_OPS [3] = '{OP_SB, OP_SH, OP_SW};

    logic clk, rst_n, rdy, clr, dp_en, ex_en, store_en;
    logic res_en, store_done, full;
    op_t dp_op;
    imm_t dp_imm;
    logic [NW-1:0] dp_rd_nick, dp_rs1_nick, dp_rs2_nick, ex_nick, store_nick, res_nick;
    data_t dp_rs1_data, dp_rs2_data, ex_data, res_data;

    logic [7:0] ref_mem [1024];
    logic [31:0] lfsr;
    logic exp_v [16];
    data_t exp_d [16];
    addr_t st_addr [16];
    len_t st_len [16];
    data_t st_data [16];
    addr_t words [$];
    int pending, errors, checks, tests;
    logic prev_rdy;

    lsu_top #(.NICK_W(NW), .MEM_AW(10)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic len_t op_len(input op_t op);
        if (op == OP_LB || op == OP_LBU || op == OP_SB) return LEN_ONE;
        if (op == OP_LH || op == OP_LHU || op == OP_SH) return LEN_TWO;
        return LEN_FOUR;
    endfunction

    // rv32 load rules on the reference memory
    function automatic data_t load_value(input addr_t a, input op_t op);
        logic [9:0] i;
        data_t raw;
        i = a[9:0];
        raw = {ref_mem[i + 10'd3], ref_mem[i + 10'd2], ref_mem[i + 10'd1], ref_mem[i]};
        case (op)
            OP_LB:   return {{24{raw[7]}}, raw[7:0]};
            OP_LBU:  return {24'h0, raw[7:0]};
            OP_LH:   return {{16{raw[15]}}, raw[15:0]};
            OP_LHU:  return {16'h0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    function automatic addr_t align_in_word(input addr_t word, input op_t op);
        if (op_len(op) == LEN_ONE) return word + rand_bits(2);
        if (op_len(op) == LEN_TWO) return word + {rand_bits(1), 1'b0};
        return word;
    endfunction

    function automatic imm_t small_imm();
        logic [31:0] r;
        r = rand_bits(6);
        return {{26{r[5]}}, r[5:0]};
    endfunction

    task automatic dispatch(input op_t op, input int rd, input int rs1n, input data_t rs1d,
                            input int rs2n, input data_t rs2d, input imm_t imm);
        @(posedge clk);
        dp_en       <= 1'b1;
        dp_op       <= op;
        dp_imm      <= imm;
        dp_rd_nick  <= NW'(rd);
        dp_rs1_nick <= NW'(rs1n);
        dp_rs1_data <= rs1d;
        dp_rs2_nick <= NW'(rs2n);
        dp_rs2_data <= rs2d;
        @(posedge clk);
        dp_en <= 1'b0;
    endtask

    task automatic arm_load(input int rd);
        exp_v[rd] = 1'b1;
        pending++;
    endtask

    // a waiting operand gets inverted data so a wrong capture shows
    task automatic send_load(input op_t op, input int rd, input int rs1n, input data_t base,
                             input imm_t imm, input bit arm);
        exp_d[rd] = load_value(base + imm, op);
        dispatch(op, rd, rs1n, (rs1n == 0) ? base : ~base, 0, '0, imm);
        if (arm) arm_load(rd);
    endtask

    task automatic send_store(input op_t op, input int rd, input int rs1n, input data_t base,
                              input int rs2n, input data_t wdata, input imm_t imm);
        st_addr[rd] = base + imm;
        st_len[rd]  = op_len(op);
        st_data[rd] = wdata;
        dispatch(op, rd, rs1n, (rs1n == 0) ? base : ~base, rs2n,
                 (rs2n == 0) ? wdata : ~wdata, imm);
    endtask

    task automatic start_commit(input int rd);
        @(posedge clk);
        store_en   <= 1'b1;
        store_nick <= NW'(rd);
    endtask

    task automatic wait_store(input int rd);
        int n;
        n = 0;
        @(posedge clk);
        while (!store_done && n < TMO) begin
            @(posedge clk);
            n++;
        end
        store_en <= 1'b0;
        if (!store_done) begin
            errors++;
            $display("timeout waiting for store_done of nick %0d", rd);
        end else begin
            checks++;
            for (int b = 0; b < 4; b++) begin
                if (b < int'(st_len[rd])) begin
                    ref_mem[st_addr[rd][9:0] + 10'(b)] = st_data[rd][8*b +: 8];
                end
            end
        end
    endtask

    task automatic commit_store(input int rd);
        start_commit(rd);
        wait_store(rd);
    endtask

    task automatic broadcast(input int nick, input data_t d);
        @(posedge clk);
        ex_en   <= 1'b1;
        ex_nick <= NW'(nick);
        ex_data <= d;
        @(posedge clk);
        ex_en <= 1'b0;
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(posedge clk);
            if (store_done) begin
                errors++;
                $display("store_done appeared while no store could issue at %0t", $time);
            end
        end
    endtask

    task automatic wait_loads();
        int n;
        n = 0;
        while (pending != 0 && n < TMO) begin
            @(posedge clk);
            n++;
        end
        if (pending != 0) begin
            errors++;
            $display("timeout with %0d loads still waiting for a result", pending);
        end
    endtask

    task automatic finish_test(input string name);
        wait_loads();
        // idle cycles to catch a repeated result
        repeat (8) @(posedge clk);
        tests++;
        $display("test %0d (%s) finished, errors so far %0d", tests, name, errors);
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (!prev_rdy && (res_en || store_done)) begin
                errors++;
                $display("result or store_done during a stall at %0t", $time);
            end
            if (res_en) begin
                if (!exp_v[res_nick]) begin
                    errors++;
                    $display("load result for nick %0d with no outstanding load at %0t",
                             res_nick, $time);
                end else begin
                    checks++;
                    if (res_data !== exp_d[res_nick]) begin
                        errors++;
                        $display("ERROR t=%0t res_data nick %0d: got %08h expected %08h",
                                 $time, res_nick, res_data, exp_d[res_nick]);
                    end
                    exp_v[res_nick] = 1'b0;
                    pending--;
                end
            end
        end
        prev_rdy = rdy;
    end

    initial begin
        op_t op;
        addr_t a;
        imm_t imm;
        data_t d;
        data_t p;
        data_t bases [16];
        int r;
        lfsr = 32'h5d96_d891;
        errors = 0;
        checks = 0;
        tests = 0;
        pending = 0;
        prev_rdy = 1'b1;
        for (int i = 0; i < 1024; i++) ref_mem[i] = 8'h00;
        for (int i = 0; i < 16; i++) exp_v[i] = 1'b0;
        rst_n = 1'b0;
        rdy = 1'b1;
        clr = 1'b0;
        dp_en = 1'b0;
        dp_op = '0;
        dp_imm = '0;
        dp_rd_nick = '0;
        dp_rs1_nick = '0;
        dp_rs1_data = '0;
        dp_rs2_nick = '0;
        dp_rs2_data = '0;
        ex_en = 1'b0;
        ex_nick = '0;
        ex_data = '0;
        store_en = 1'b0;
        store_nick = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // stores of every size, then loads of every kind
        for (int i = 0; i < 6; i++) begin
            op = ST_OPS[i % 3];
            a = align_in_word({rand_bits(6), 2'b00}, op);
            imm = small_imm();
            words.push_back({a[31:2], 2'b00});
            send_store(op, i + 1, 0, a - imm, 0, rand_bits(32), imm);
            commit_store(i + 1);
        end
        for (int i = 0; i < 9; i++) begin
            op = LD_OPS[i % 5];
            a = align_in_word(words[i % 6], op);
            imm = small_imm();
            send_load(op, i + 1, 0, a - imm, imm, 1'b1);
        end
        finish_test("store then load");

        // operands arrive later on the ex bus
        for (int i = 0; i < 3; i++) begin
            op = ST_OPS[rand_bits(2) % 3];
            a = align_in_word({rand_bits(6), 2'b00}, op);
            imm = small_imm();
            d = rand_bits(32);
            send_store(op, i + 1, 9, a - imm, 10, d, imm);
            start_commit(i + 1);
            expect_quiet(3);
            if (rand_bits(1)) begin
                broadcast(9, a - imm);
                expect_quiet(2);
                broadcast(10, d);
            end else begin
                broadcast(10, d);
                expect_quiet(2);
                broadcast(9, a - imm);
            end
            wait_store(i + 1);
        end
        for (int i = 0; i < 4; i++) begin
            op = LD_OPS[rand_bits(3) % 5];
            a = align_in_word(words[rand_bits(3) % words.size()], op);
            imm = small_imm();
            bases[i] = a - imm;
            send_load(op, i + 1, 11 + i, bases[i], imm, 1'b0);
        end
        repeat (4) @(posedge clk);
        r = int'(rand_bits(2));
        for (int j = 0; j < 4; j++) begin
            arm_load((j + r) % 4 + 1);
            broadcast(11 + (j + r) % 4, bases[(j + r) % 4]);
        end
        finish_test("operand wakeup");

        // pointer chase through the load result bus
        p = {rand_bits(6), 2'b00};
        a = 32'd512 + {rand_bits(6), 2'b00};
        send_store(OP_SW, 1, 0, a, 0, p, '0);
        commit_store(1);
        for (int i = 0; i < 3; i++) begin
            op = LD_OPS[rand_bits(3) % 5];
            imm = align_in_word({rand_bits(4), 2'b00}, op);
            send_load(OP_LW, 2 * i + 2, 0, a, '0, 1'b1);
            send_load(op, 2 * i + 3, 2 * i + 2, p, imm, 1'b1);
        end
        finish_test("load to load");

        // fourteen loads wait on the fifteenth
        p = {rand_bits(6), 2'b00};
        a = 32'd768 + {rand_bits(6), 2'b00};
        send_store(OP_SW, 1, 0, a, 0, p, '0);
        commit_store(1);
        for (int i = 1; i < 15; i++) begin
            op = LD_OPS[rand_bits(3) % 5];
            imm = align_in_word({rand_bits(4), 2'b00}, op);
            send_load(op, i, 15, p, imm, 1'b1);
        end
        send_load(OP_LW, 15, 0, a, '0, 1'b1);
        @(posedge clk);
        checks++;
        if (full !== 1'b1) begin
            errors++;
            $display("ERROR t=%0t full: got %b expected 1", $time, full);
        end
        finish_test("full");

        // stall with loads in flight
        for (int i = 1; i < 3; i++) begin
            a = words[rand_bits(3) % words.size()];
            send_load(OP_LW, i, 0, a, '0, 1'b1);
        end
        repeat (2) @(posedge clk);
        rdy <= 1'b0;
        repeat (8) @(posedge clk);
        rdy <= 1'b1;
        wait_loads();
        // a filled buffer and its store are dropped by the flush
        a = words[rand_bits(3) % words.size()];
        for (int i = 1; i < 15; i++) begin
            dispatch(OP_LW, i, 15, '0, 0, '0, '0);
        end
        send_store(OP_SW, 15, 0, a, 0, rand_bits(32), '0);
        @(posedge clk);
        clr <= 1'b1;
        @(posedge clk);
        clr <= 1'b0;
        @(posedge clk);
        checks++;
        if (full !== 1'b0) begin
            errors++;
            $display("ERROR t=%0t full: got %b expected 0", $time, full);
        end
        start_commit(15);
        expect_quiet(4);
        store_en <= 1'b0;
        send_load(OP_LW, 4, 0, a, '0, 1'b1);
        finish_test("stall and flush");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/lsu_types_pkg.sv
logic/lsu_op_pkg.sv
logic/mem_op_decode.sv
logic/slb.sv
logic/data_mem.sv
logic/load_result.sv
logic/lsu_top.sv
test/lsu_checker.sv
test/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the lsu testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module lsu_tb \
    --Mdir obj_dir -o lsu_sim > build.log 2>&1 \
    && ./obj_dir/lsu_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "^STATUS: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
